// ==== msx_io_subsystem.f ====
hw/msx_io_pkg.sv
hw/ip_ppi_mirror.sv
hw/msx_slot_select.sv
hw/msx_key_matrix.sv
hw/msx_io_subsystem.sv
tests/tb_msx_io_subsystem.sv

// ==== tests/tb_msx_io_subsystem.sv ====
`timescale 1ns/1ps

module tb_msx_io_subsystem
	import msx_io_pkg::*;
();

	logic        clk;
	logic        n_reset;
	logic [15:0] bus_address;
	logic [7:0]  bus_write_data;
	logic        bus_read;
	logic        bus_write;
	logic        bus_io;
	logic        bus_memory;
	logic [7:0]  bus_read_data;
	logic        bus_io_cs;
	logic [3:0]  slot_select;
	logic        motor_off;
	logic        cas_write;
	logic        caps_led_off;
	logic        click_sound;
	logic [3:0]  key_matrix_row;
	logic        key_event;
	logic [3:0]  key_code_row;
	logic [2:0]  key_code_column;
	logic        key_pressed;

	logic [31:0] lcg_state = 32'hcee2e703;
	int          errors = 0;
	int          start_errors = 0;
	int          tests_ok = 0;
	int          tests_bad = 0;
	// what the PPI registers should hold, kept by the tests
	logic [7:0]  shadow_slot = 8'h00;
	logic [7:0]  shadow_port_c = 8'h7F;
	// pressed bits per row, 1 = key down
	logic [7:0]  key_model [key_rows];

	msx_io_subsystem uut (.*);

	// 8 ns clock
	always #4 clk = ~clk;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
		if (got !== exp) begin
			$display("MISMATCH %0t ns: %s got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic compare_port_c(input ppi_port_c_t got, input ppi_port_c_t exp,
			input string msg);
		if (got.raw !== exp.raw) begin
			$display("MISMATCH %0t ns: %s port C lines %h expected %h", $time, msg,
				got.raw, exp.raw);
			errors++;
		end
	endtask

	task automatic compare_slot(input logic [3:0] got, input logic [3:0] exp, input string msg);
		if (got !== exp) begin
			$display("MISMATCH %0t ns: %s slot %b expected %b", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic bus_idle();
		bus_address    = 16'h0000;
		bus_write_data = 8'h00;
		bus_read       = 1'b0;
		bus_write      = 1'b0;
		bus_io         = 1'b0;
		bus_memory     = 1'b0;
	endtask

	// one-cycle I/O write, taken on the edge that ends the cycle
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		bus_address    = addr;
		bus_write_data = data;
		bus_io         = 1'b1;
		bus_write      = 1'b1;
		@(posedge clk);
		#1;
		bus_idle();
	endtask

	// data and chip select sampled mid cycle, well away from the edges
	task automatic io_read(input logic [15:0] addr, output logic [7:0] data, output logic cs);
		@(posedge clk);
		#1;
		bus_address = addr;
		bus_io      = 1'b1;
		bus_read    = 1'b1;
		@(negedge clk);
		data = bus_read_data;
		cs   = bus_io_cs;
		@(posedge clk);
		#1;
		bus_idle();
	endtask

	task automatic mem_access(input logic [15:0] addr, input logic wr, input logic [7:0] data,
			output logic [3:0] slot, output logic cs);
		@(posedge clk);
		#1;
		bus_address    = addr;
		bus_write_data = data;
		bus_memory     = 1'b1;
		bus_write      = wr;
		bus_read       = !wr;
		@(negedge clk);
		slot = slot_select;
		cs   = bus_io_cs;
		@(posedge clk);
		#1;
		bus_idle();
	endtask

	task automatic key_set(input logic [3:0] row, input logic [2:0] col, input logic pressed);
		@(posedge clk);
		#1;
		key_event       = 1'b1;
		key_code_row    = row;
		key_code_column = col;
		key_pressed     = pressed;
		@(posedge clk);
		#1;
		key_event = 1'b0;
	endtask

	// control lines rebuilt bit by bit, click is bit 7 and the row bits 3..0
	task automatic check_port_c_lines(input logic [7:0] exp_byte, input string msg);
		ppi_port_c_t got;
		ppi_port_c_t exp;
		@(negedge clk);
		got.raw = {click_sound, caps_led_off, cas_write, motor_off, key_matrix_row};
		exp.raw = exp_byte;
		compare_port_c(got, exp, msg);
	endtask

	task automatic end_test(input string name);
		if (errors == start_errors) begin
			$display("%s: ok", name);
			tests_ok++;
		end else begin
			$display("%s: %0d errors", name, errors - start_errors);
			tests_bad++;
		end
		start_errors = errors;
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------

	task automatic test_reset_values();
		logic [7:0] d;
		logic [3:0] slot;
		logic       cs;
		check_port_c_lines(8'h7F, "reset lines");
		io_read(16'h00A8, d, cs);
		compare_byte(d, 8'h00, "reset read A8h");
		io_read(16'h00A9, d, cs);
		compare_byte(d, 8'hFF, "reset read A9h");
		io_read(16'h00AA, d, cs);
		compare_byte(d, 8'h7F, "reset read AAh");
		for (int p = 0; p < 4; p++) begin
			mem_access({p[1:0], 14'h0123}, 1'b0, 8'h00, slot, cs);
			compare_slot(slot, 4'b0001, "reset slot");
		end
		// every real row starts with all keys up
		for (int row = 0; row < key_rows; row++) begin
			io_write(16'h00AA, {4'h7, row[3:0]});
			io_read(16'h00A9, d, cs);
			compare_byte(d, 8'hFF, "reset key row");
		end
		end_test("reset_values");
	endtask

	task automatic test_port_c_writes();
		logic [31:0] r;
		logic [7:0]  b;
		logic [7:0]  d;
		logic        cs;
		for (int i = 0; i < 12; i++) begin
			r = lcg_next();
			b = r[15:8];
			io_write(16'h00AA, b);
			check_port_c_lines(b, "port C lines");
			io_read(16'h00AA, d, cs);
			compare_byte(d, b, "port C read back");
		end
		shadow_port_c = b;
		end_test("port_c_writes");
	endtask

	task automatic test_primary_slot();
		logic [31:0] r;
		logic [7:0]  ps;
		logic [3:0]  slot;
		logic        cs;
		logic [15:0] addr;
		for (int i = 0; i < 8; i++) begin
			r  = lcg_next();
			ps = r[23:16];
			io_write(16'h00A8, ps);
			for (int p = 0; p < 4; p++) begin
				r    = lcg_next();
				addr = {p[1:0], r[31:18]};
				mem_access(addr, 1'b0, 8'h00, slot, cs);
				// page p uses bits 2p+1..2p of port A
				compare_slot(slot, 4'b0001 << ps[2*p +: 2], "page slot");
			end
		end
		shadow_slot = ps;
		end_test("primary_slot");
	endtask

	task automatic test_key_matrix();
		logic [31:0] r;
		logic [31:0] idx;
		logic [3:0]  row;
		logic [7:0]  d;
		logic        cs;
		for (int i = 0; i < key_rows; i++) begin
			key_model[i] = 8'h00;
		end
		// mostly presses, a release every fourth event
		for (int i = 0; i < 24; i++) begin
			r   = lcg_next();
			idx = (r >> 8) % key_rows;
			row = idx[3:0];
			key_set(row, r[18:16], r[25:24] != 2'b00);
			key_model[row][r[18:16]] = (r[25:24] != 2'b00);
		end
		for (int i = 0; i < key_rows; i++) begin
			io_write(16'h00AA, {4'h7, i[3:0]});
			io_read(16'h00A9, d, cs);
			compare_byte(d, ~key_model[i], "key row column byte");
		end
		// row 12 exists in the row code but holds no keys
		io_write(16'h00AA, 8'h7C);
		io_read(16'h00A9, d, cs);
		compare_byte(d, 8'hFF, "empty row 12");
		shadow_port_c = 8'h7C;
		end_test("key_matrix");
	endtask

	task automatic test_decode();
		logic [31:0] r;
		logic [7:0]  d;
		logic [7:0]  exp_d;
		logic [3:0]  slot;
		logic        cs;
		logic        exp_cs;
		logic [15:0] addr;
		// inverted data so a stray write always shows in the registers
		io_write(16'h00AB, ~shadow_port_c);
		io_write(16'h00A6, ~shadow_port_c);
		io_write(16'h00AC, ~shadow_slot);
		io_write(16'h0028, ~shadow_slot);
		mem_access(16'h00A8, 1'b1, ~shadow_slot, slot, cs);
		compare_byte({7'b0, cs}, 8'h00, "io_cs in memory write");
		mem_access(16'h00AA, 1'b1, ~shadow_port_c, slot, cs);
		check_port_c_lines(shadow_port_c, "lines after foreign writes");
		// every low address byte with a random high byte, only A8h..ABh answer
		for (int a = 0; a < 256; a++) begin
			r      = lcg_next();
			addr   = {r[31:24], a[7:0]};
			exp_cs = (a[7:2] == 6'b101010);
			case (a)
				8'hA8:   exp_d = shadow_slot;
				8'hAA:   exp_d = shadow_port_c;
				8'hA9,
				8'hAB:   exp_d = 8'hFF;
				default: exp_d = 8'h00;
			endcase
			io_read(addr, d, cs);
			compare_byte({7'b0, cs}, {7'b0, exp_cs}, $sformatf("io_cs at %h", addr));
			compare_byte(d, exp_d, $sformatf("read at %h", addr));
		end
		end_test("decode");
	endtask

	// ------------------------------------------------------------------------
	// run
	// ------------------------------------------------------------------------

	initial begin
		clk             = 1'b0;
		n_reset         = 1'b0;
		key_event       = 1'b0;
		key_code_row    = 4'h0;
		key_code_column = 3'h0;
		key_pressed     = 1'b0;
		bus_idle();
		repeat (4) @(posedge clk);
		#1;
		n_reset = 1'b1;
		test_reset_values();
		test_port_c_writes();
		test_primary_slot();
		test_key_matrix();
		test_decode();
		$display("summary: %0d ok, %0d with errors, %0d mismatches", tests_ok, tests_bad,
			errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// watchdog, the whole run fits well inside this bound
	initial begin
		for (int c = 0; c < 20000; c++) begin
			@(posedge clk);
		end
		$display("timeout: run did not finish within 20000 clock cycles");
		$display("test failed");
		$finish;
	end

endmodule

// ==== hw/msx_io_subsystem.sv ====
`timescale 1ns/1ps

module msx_io_subsystem
	import msx_io_pkg::*;
(
	input  logic                    clk,
	input  logic                    n_reset,
	// cpu side bus
	input  logic [15:0]             bus_address,
	input  logic [7:0]              bus_write_data,
	input  logic                    bus_read,
	input  logic                    bus_write,
	input  logic                    bus_io,
	input  logic                    bus_memory,
	output logic [7:0]              bus_read_data,
	output logic                    bus_io_cs,
	// primary slot enables
	output logic [3:0]              slot_select,
	// port C control lines
	output logic                    motor_off,
	output logic                    cas_write,
	output logic                    caps_led_off,
	output logic                    click_sound,
	// row under scan, brought out for observation
	output logic [key_row_bits-1:0] key_matrix_row,
	// key events from outside
	input  logic                    key_event,
	input  logic [key_row_bits-1:0] key_code_row,
	input  logic [2:0]              key_code_column,
	input  logic                    key_pressed
);

	logic [7:0] primary_slot;
	logic [7:0] key_matrix_column;

	// ------------------------------------------------------------------------
	// PPI, ports A8h..ABh
	// ------------------------------------------------------------------------

	ip_ppi_mirror u_ppi (
		.clk               (clk),
		.n_reset           (n_reset),
		.bus_address       (bus_address),
		.bus_write_data    (bus_write_data),
		.bus_read          (bus_read),
		.bus_write         (bus_write),
		.bus_io            (bus_io),
		.bus_io_cs         (bus_io_cs),
		.bus_read_data     (bus_read_data),
		.primary_slot      (primary_slot),
		.key_matrix_row    (key_matrix_row),
		.key_matrix_column (key_matrix_column),
		.motor_off         (motor_off),
		.cas_write         (cas_write),
		.caps_led_off      (caps_led_off),
		.click_sound       (click_sound)
	);

	// ------------------------------------------------------------------------
	// primary slot decode
	// ------------------------------------------------------------------------

	// purely combinational from the current address and port A
	msx_slot_select u_slot (
		.bus_address  (bus_address),
		.bus_memory   (bus_memory),
		.primary_slot (primary_slot),
		.slot_select  (slot_select)
	);

	// ------------------------------------------------------------------------
	// keyboard matrix
	// ------------------------------------------------------------------------

	// row comes from port C, column byte goes back as port B
	msx_key_matrix u_keys (
		.clk               (clk),
		.n_reset           (n_reset),
		.key_event         (key_event),
		.key_code_row      (key_code_row),
		.key_code_column   (key_code_column),
		.key_pressed       (key_pressed),
		.key_matrix_row    (key_matrix_row),
		.key_matrix_column (key_matrix_column)
	);

endmodule

// ==== hw/msx_key_matrix.sv ====
`timescale 1ns/1ps

module msx_key_matrix
	import msx_io_pkg::*;
(
	input  logic                    clk,
	input  logic                    n_reset,
	// key events from outside, one clk strobe per change
	input  logic                    key_event,
	input  logic [key_row_bits-1:0] key_code_row,
	input  logic [2:0]              key_code_column,
	// 1 for a press, 0 for a release
	input  logic                    key_pressed,
	// scan side, row from PPI port C
	input  logic [key_row_bits-1:0] key_matrix_row,
	// active low, a pressed key pulls its bit to 0
	output logic [7:0]              key_matrix_column
);

	// one byte of pressed bits per row, 1 = key down
	logic [7:0] ff_pressed [key_rows];
	logic       event_row_ok;
	logic       scan_row_ok;

	// ------------------------------------------------------------------------
	// row range checks
	// ------------------------------------------------------------------------

	// rows 11..15 exist in the row code but carry no keys
	assign event_row_ok = (key_code_row < key_rows);
	assign scan_row_ok  = (key_matrix_row < key_rows);

	// ------------------------------------------------------------------------
	// key state update
	// ------------------------------------------------------------------------

	// every key starts released after reset
	// a single event touches one bit, the rest of the row is kept
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			for (int i = 0; i < key_rows; i++) begin
				ff_pressed[i] <= 8'h00;
			end
		end else if (key_event && event_row_ok) begin
			ff_pressed[key_code_row][key_code_column] <= key_pressed;
		end
	end

	// ------------------------------------------------------------------------
	// row read out
	// ------------------------------------------------------------------------

	// inverted here so the PPI sees the active low column byte of a real
	// MSX keyboard
	// empty rows read as all keys up
	always_comb begin
		if (scan_row_ok) begin
			key_matrix_column = ~ff_pressed[key_matrix_row];
		end else begin
			key_matrix_column = 8'hFF;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// the key source only reports keys that exist
	a_event_row_range: assert property (
		@(posedge clk) disable iff (!n_reset)
		key_event |-> (key_code_row < key_rows)
	) else $error("key event on row %0d outside the matrix", key_code_row);

endmodule

// ==== hw/msx_slot_select.sv ====
`timescale 1ns/1ps

module msx_slot_select (
	// memory side of the cpu bus
	input  logic [15:0] bus_address,
	input  logic        bus_memory,
	// primary slot register from PPI port A
	input  logic [7:0]  primary_slot,
	// one-hot slot enable
	output logic [3:0]  slot_select
);

	logic [1:0] page;
	logic [1:0] slot;

	// ------------------------------------------------------------------------
	// page to slot lookup
	// ------------------------------------------------------------------------

	// the 64k space is four 16k pages, page n uses bits 2n+1..2n of port A
	assign page = bus_address[15:14];

	always_comb begin
		case (page)
			2'd0:    slot = primary_slot[1:0];
			2'd1:    slot = primary_slot[3:2];
			2'd2:    slot = primary_slot[5:4];
			default: slot = primary_slot[7:6];
		endcase
	end

	// ------------------------------------------------------------------------
	// one-hot select
	// ------------------------------------------------------------------------

	// only drive a select during a memory cycle, I/O cycles leave every
	// slot idle
	always_comb begin
		slot_select = 4'b0000;
		if (bus_memory) begin
			case (slot)
				2'd0:    slot_select = 4'b0001;
				2'd1:    slot_select = 4'b0010;
				2'd2:    slot_select = 4'b0100;
				default: slot_select = 4'b1000;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// no clock here, so a deferred check once the inputs have settled
	// exactly one slot in a memory cycle, none outside it
	always_comb begin
		if (bus_memory) begin
			a_slot_onehot: assert final ($onehot(slot_select))
				else $error("slot_select not one-hot in memory cycle: %b", slot_select);
		end else begin
			a_slot_idle: assert final (slot_select == 4'b0000)
				else $error("slot_select active outside memory cycle: %b", slot_select);
		end
	end

endmodule

// ==== hw/ip_ppi_mirror.sv ====
`timescale 1ns/1ps

module ip_ppi_mirror
	import msx_io_pkg::*;
(
	input  logic                    clk,
	input  logic                    n_reset,
	// cpu side bus
	input  logic [15:0]             bus_address,
	input  logic [7:0]              bus_write_data,
	input  logic                    bus_read,
	input  logic                    bus_write,
	input  logic                    bus_io,
	output logic                    bus_io_cs,
	output logic [7:0]              bus_read_data,
	// slot register towards the slot selector
	output logic [7:0]              primary_slot,
	// keyboard scan
	output logic [key_row_bits-1:0] key_matrix_row,
	input  logic [7:0]              key_matrix_column,
	// port C control lines
	output logic                    motor_off,
	output logic                    cas_write,
	output logic                    caps_led_off,
	output logic                    click_sound
);

	logic        ppi_dec;
	logic        ppi_wr;
	logic        ppi_rd;
	logic [1:0]  port_sel;
	logic [7:0]  ff_primary_slot;
	ppi_port_c_t ff_port_c;

	// ------------------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------------------

	// match on bits 7..2 only, the high byte of an I/O address is ignored
	assign ppi_dec   = (bus_address[7:2] == ppi_base_addr[7:2]);
	assign port_sel  = bus_address[1:0];

	// chip select only counts in an I/O cycle
	assign bus_io_cs = bus_io && ppi_dec;

	// strobes are levels, a long write just rewrites the same value
	assign ppi_wr    = bus_io_cs && bus_write;
	assign ppi_rd    = bus_io_cs && bus_read;

	// ------------------------------------------------------------------------
	// write registers
	// ------------------------------------------------------------------------

	// port A holds the primary slot register, port C the keyboard row and
	// the cassette / led / click bits
	// port B is input only and the mode port is not modelled
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_primary_slot <= primary_slot_reset;
			ff_port_c.raw   <= port_c_reset;
		end else if (ppi_wr) begin
			case (port_sel)
				ppi_port_a: begin
					ff_primary_slot <= bus_write_data;
				end
				ppi_port_c: begin
					ff_port_c.raw <= bus_write_data;
				end
				default: begin
					// port B and mode writes are dropped
				end
			endcase
		end
	end

	// control outputs come straight from the field view
	assign primary_slot   = ff_primary_slot;
	assign key_matrix_row = ff_port_c.field.row;
	assign motor_off      = ff_port_c.field.motor_off;
	assign cas_write      = ff_port_c.field.cas_write;
	assign caps_led_off   = ff_port_c.field.caps_led_off;
	assign click_sound    = ff_port_c.field.click_sound;

	// ------------------------------------------------------------------------
	// read back
	// ------------------------------------------------------------------------

	// combinational, data is valid in the cycle of the read strobe
	// idle bus reads as 00h so it can be or-ed with other devices
	always_comb begin
		bus_read_data = 8'h00;
		if (ppi_rd) begin
			case (port_sel)
				ppi_port_a:    bus_read_data = ff_primary_slot;
				// port B is the column byte of the row selected in port C
				ppi_port_b:    bus_read_data = key_matrix_column;
				ppi_port_c:    bus_read_data = ff_port_c.raw;
				ppi_port_mode: bus_read_data = 8'hFF;
				default:       bus_read_data = 8'h00;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// the cpu never drives both strobes in one I/O cycle
	a_io_rd_wr_exclusive: assert property (
		@(posedge clk) disable iff (!n_reset)
		bus_io |-> !(bus_read && bus_write)
	) else $error("bus_read and bus_write both high in an I/O cycle");

endmodule

// ==== hw/msx_io_pkg.sv ====
package msx_io_pkg;

	// ------------------------------------------------------------------------
	// PPI I/O window
	// ------------------------------------------------------------------------

	// the PPI sits at A8h..ABh, only address bits 7..2 take part in the decode
	localparam logic [7:0] ppi_base_addr = 8'hA8;

	// port index taken from address bits 1..0
	localparam logic [1:0] ppi_port_a    = 2'd0;
	localparam logic [1:0] ppi_port_b    = 2'd1;
	localparam logic [1:0] ppi_port_c    = 2'd2;
	// mode register, writes are dropped and reads give FFh
	localparam logic [1:0] ppi_port_mode = 2'd3;

	// ------------------------------------------------------------------------
	// reset values
	// ------------------------------------------------------------------------

	// all four pages start in slot 0
	localparam logic [7:0] primary_slot_reset = 8'h00;
	// row F, motor off, cas write high, caps led off, click low
	localparam logic [7:0] port_c_reset       = 8'h7F;

	// ------------------------------------------------------------------------
	// keyboard
	// ------------------------------------------------------------------------

	// rows 0..10 carry keys on an MSX body
	localparam int key_rows     = 11;
	// width of the row index in port C and in key events
	localparam int key_row_bits = 4;

	// ------------------------------------------------------------------------
	// port C byte
	// ------------------------------------------------------------------------

	// written from the bus as a whole byte, read by the rest of the body
	// bit by bit
	typedef union packed {
		// plain byte as it travels on the data bus
		logic [7:0] raw;
		// msb first, so click_sound is bit 7 and row is bits 3..0
		struct packed {
			logic                    click_sound;
			logic                    caps_led_off;
			logic                    cas_write;
			logic                    motor_off;
			logic [key_row_bits-1:0] row;
		} field;
	} ppi_port_c_t;

endpackage
